// File: hdl/mips_pkg.sv
package mips_pkg;

   // opcodes
   localparam logic [5:0] OP_RTYPE = 6'b000000;
   localparam logic [5:0] OP_J     = 6'b000010;
   localparam logic [5:0] OP_JAL   = 6'b000011;
   localparam logic [5:0] OP_BEQ   = 6'b000100;
   localparam logic [5:0] OP_BNE   = 6'b000101;
   localparam logic [5:0] OP_ADDIU = 6'b001001;
   localparam logic [5:0] OP_ANDI  = 6'b001100;
   localparam logic [5:0] OP_ORI   = 6'b001101;
   localparam logic [5:0] OP_LUI   = 6'b001111;
   localparam logic [5:0] OP_LB    = 6'b100000;
   localparam logic [5:0] OP_LH    = 6'b100001;
   localparam logic [5:0] OP_LW    = 6'b100011;
   localparam logic [5:0] OP_LBU   = 6'b100100;
   localparam logic [5:0] OP_LHU   = 6'b100101;
   localparam logic [5:0] OP_SB    = 6'b101000;
   localparam logic [5:0] OP_SH    = 6'b101001;
   localparam logic [5:0] OP_SW    = 6'b101011;

   // R-type function codes
   localparam logic [5:0] FN_SLL  = 6'b000000;
   localparam logic [5:0] FN_SRL  = 6'b000010;
   localparam logic [5:0] FN_SRA  = 6'b000011;
   localparam logic [5:0] FN_JR   = 6'b001000;
   localparam logic [5:0] FN_ADDU = 6'b100001;
   localparam logic [5:0] FN_SUBU = 6'b100011;
   localparam logic [5:0] FN_AND  = 6'b100100;
   localparam logic [5:0] FN_OR   = 6'b100101;
   localparam logic [5:0] FN_XOR  = 6'b100110;
   localparam logic [5:0] FN_SLT  = 6'b101010;

   typedef enum logic [3:0] {
      ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
      ALU_SLT, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
   } alu_op_t;

   typedef enum logic [1:0] {SRC_A_REG, SRC_A_FWD, SRC_A_SHAMT} src_a_t;
   typedef enum logic [1:0] {SRC_B_REG, SRC_B_FWD, SRC_B_SIMM, SRC_B_ZIMM} src_b_t;
   typedef enum logic [1:0] {WB_ALU, WB_LOAD, WB_CNT, WB_LINK} wb_sel_t;
   typedef enum logic [1:0] {NPC_SEQ, NPC_BRANCH, NPC_JUMP, NPC_REG} next_pc_t;

   // destination register select
   localparam logic [1:0] DST_RT = 2'd0;
   localparam logic [1:0] DST_RD = 2'd1;
   localparam logic [1:0] DST_RA = 2'd2;

   // access size, same as opcode bits 27:26 of loads and stores
   localparam logic [1:0] SZ_BYTE = 2'b00;
   localparam logic [1:0] SZ_HALF = 2'b01;
   localparam logic [1:0] SZ_WORD = 2'b11;

   // counter window: +0 cycles, +4 instructions, store to +8 clears
   localparam logic [31:0] CNT_BASE = 32'h8000_0000;

endpackage

// File: hdl/alu.sv
`timescale 1ns/1ps

module alu (
   input  logic [31:0]       a,
   input  logic [31:0]       b,
   input  mips_pkg::alu_op_t op,
   output logic [31:0]       result
);

   always_comb begin
      case (op)
         mips_pkg::ALU_ADD: result = a + b;
         mips_pkg::ALU_SUB: result = a - b;
         mips_pkg::ALU_AND: result = a & b;
         mips_pkg::ALU_OR:  result = a | b;
         mips_pkg::ALU_XOR: result = a ^ b;
         mips_pkg::ALU_SLT: result = {31'b0, $signed(a) < $signed(b)};
         mips_pkg::ALU_SLL: result = b << a[4:0];    // amount always from a
         mips_pkg::ALU_SRL: result = b >> a[4:0];
         mips_pkg::ALU_SRA: result = $unsigned($signed(b) >>> a[4:0]);
         mips_pkg::ALU_LUI: result = {b[15:0], 16'h0000};
         default:           result = 32'h0;
      endcase
   end

endmodule

// File: hdl/reg_file.sv
`timescale 1ns/1ps

module reg_file (
   input  logic        CLK,
   input  logic        we,
   input  logic [4:0]  ra1,
   input  logic [4:0]  ra2,
   input  logic [4:0]  wa,
   input  logic [31:0] wd,
   output logic [31:0] rd1,
   output logic [31:0] rd2
);

   logic [31:0] regs [0:31];

   always_ff @(posedge CLK) begin
      if (we && wa != 5'd0) begin
         regs[wa] <= wd;
      end
   end

   // same-cycle write is seen by the reader
   assign rd1 = (ra1 == 5'd0) ? 32'h0 : (we && wa == ra1) ? wd : regs[ra1];
   assign rd2 = (ra2 == 5'd0) ? 32'h0 : (we && wa == ra2) ? wd : regs[ra2];

endmodule

// File: hdl/load_store_align.sv
`timescale 1ns/1ps

module load_store_align (
   input  logic [1:0]  size,
   input  logic        sign_ext,
   input  logic [1:0]  ex_offset,
   input  logic [1:0]  wb_offset,
   input  logic [31:0] store_data,
   input  logic [31:0] mem_rdata,
   output logic [31:0] lane_data,
   output logic [31:0] store_lanes,
   output logic [3:0]  byte_en
);

   logic [7:0]  ld_byte;
   logic [15:0] ld_half;

   // big-endian, offset 0 sits in bits 31:24
   assign ld_byte = mem_rdata[{~wb_offset, 3'b000} +: 8];
   assign ld_half = wb_offset[1] ? mem_rdata[15:0] : mem_rdata[31:16];

   always_comb begin
      case (size)
         mips_pkg::SZ_BYTE: lane_data = {{24{sign_ext & ld_byte[7]}}, ld_byte};
         mips_pkg::SZ_HALF: lane_data = {{16{sign_ext & ld_half[15]}}, ld_half};
         default:           lane_data = mem_rdata;
      endcase
   end

   always_comb begin
      case (size)
         mips_pkg::SZ_BYTE: begin
            store_lanes = {24'h0, store_data[7:0]} << {~ex_offset, 3'b000};
            byte_en     = 4'b1000 >> ex_offset;
         end
         mips_pkg::SZ_HALF: begin
            // offset bit 0 ignored, halfwords are aligned
            store_lanes = ex_offset[1] ? {16'h0, store_data[15:0]}
                                       : {store_data[15:0], 16'h0};
            byte_en     = ex_offset[1] ? 4'b0011 : 4'b1100;
         end
         default: begin
            store_lanes = store_data;
            byte_en     = 4'b1111;
         end
      endcase
   end

endmodule

// File: hdl/control_unit.sv
`timescale 1ns/1ps

module control_unit (
   input  logic [31:0]        ex_instr,
   input  logic               branch_taken,
   input  logic               fwd_valid,
   input  logic [4:0]         fwd_reg,
   input  logic               ctr_hit,
   output mips_pkg::alu_op_t  alu_op,
   output mips_pkg::src_a_t   src_a,
   output mips_pkg::src_b_t   src_b,
   output logic [1:0]         dst_sel,
   output logic               reg_write,
   output logic               mem_read,
   output logic               mem_write,
   output logic [1:0]         mem_size,
   output logic               mem_signed,
   output mips_pkg::wb_sel_t  wb_sel,
   output mips_pkg::next_pc_t next_pc
);

   logic [5:0] opcode;
   logic [5:0] funct;
   logic       rs_fwd;
   logic       rt_fwd;

   assign opcode = ex_instr[31:26];
   assign funct  = ex_instr[5:0];

   // previous result still in write-back, $0 never forwarded
   assign rs_fwd = fwd_valid && fwd_reg != 5'd0 && fwd_reg == ex_instr[25:21];
   assign rt_fwd = fwd_valid && fwd_reg != 5'd0 && fwd_reg == ex_instr[20:16];

   assign mem_size   = ex_instr[27:26];  // byte/half/word by opcode
   assign mem_signed = ~ex_instr[28];    // lbu/lhu have bit 28 set

   always_comb begin
      alu_op    = mips_pkg::ALU_ADD;
      src_a     = rs_fwd ? mips_pkg::SRC_A_FWD : mips_pkg::SRC_A_REG;
      src_b     = rt_fwd ? mips_pkg::SRC_B_FWD : mips_pkg::SRC_B_REG;
      dst_sel   = mips_pkg::DST_RT;
      reg_write = 1'b0;
      mem_read  = 1'b0;
      mem_write = 1'b0;
      wb_sel    = mips_pkg::WB_ALU;
      next_pc   = mips_pkg::NPC_SEQ;

      case (opcode)
         mips_pkg::OP_RTYPE: begin
            dst_sel   = mips_pkg::DST_RD;
            reg_write = 1'b1;
            case (funct)
               mips_pkg::FN_ADDU: alu_op = mips_pkg::ALU_ADD;
               mips_pkg::FN_SUBU: alu_op = mips_pkg::ALU_SUB;
               mips_pkg::FN_AND:  alu_op = mips_pkg::ALU_AND;
               mips_pkg::FN_OR:   alu_op = mips_pkg::ALU_OR;
               mips_pkg::FN_XOR:  alu_op = mips_pkg::ALU_XOR;
               mips_pkg::FN_SLT:  alu_op = mips_pkg::ALU_SLT;
               mips_pkg::FN_SLL, mips_pkg::FN_SRL, mips_pkg::FN_SRA: begin
                  src_a  = mips_pkg::SRC_A_SHAMT;
                  alu_op = (funct == mips_pkg::FN_SLL) ? mips_pkg::ALU_SLL :
                           (funct == mips_pkg::FN_SRL) ? mips_pkg::ALU_SRL :
                                                         mips_pkg::ALU_SRA;
               end
               mips_pkg::FN_JR: begin
                  reg_write = 1'b0;
                  next_pc   = mips_pkg::NPC_REG;  // target is operand a
               end
               default: reg_write = 1'b0;
            endcase
         end
         mips_pkg::OP_ADDIU: begin
            src_b     = mips_pkg::SRC_B_SIMM;
            reg_write = 1'b1;
         end
         mips_pkg::OP_ANDI, mips_pkg::OP_ORI, mips_pkg::OP_LUI: begin
            src_b     = mips_pkg::SRC_B_ZIMM;
            reg_write = 1'b1;
            alu_op    = (opcode == mips_pkg::OP_ANDI) ? mips_pkg::ALU_AND :
                        (opcode == mips_pkg::OP_ORI)  ? mips_pkg::ALU_OR  :
                                                        mips_pkg::ALU_LUI;
         end
         mips_pkg::OP_LB, mips_pkg::OP_LBU, mips_pkg::OP_LH, mips_pkg::OP_LHU,
         mips_pkg::OP_LW: begin
            src_b     = mips_pkg::SRC_B_SIMM;
            reg_write = 1'b1;
            mem_read  = 1'b1;
            wb_sel    = ctr_hit ? mips_pkg::WB_CNT : mips_pkg::WB_LOAD;
         end
         mips_pkg::OP_SB, mips_pkg::OP_SH, mips_pkg::OP_SW: begin
            src_b     = mips_pkg::SRC_B_SIMM;
            mem_write = 1'b1;
         end
         mips_pkg::OP_BEQ, mips_pkg::OP_BNE: begin
            if (branch_taken) begin
               next_pc = mips_pkg::NPC_BRANCH;
            end
         end
         mips_pkg::OP_J: next_pc = mips_pkg::NPC_JUMP;
         mips_pkg::OP_JAL: begin
            next_pc   = mips_pkg::NPC_JUMP;
            dst_sel   = mips_pkg::DST_RA;
            reg_write = 1'b1;
            wb_sel    = mips_pkg::WB_LINK;
         end
         default: ;
      endcase
   end

endmodule

// File: hdl/datapath.sv
`timescale 1ns/1ps

module datapath #(
   parameter logic [31:0] RESET_PC = 32'h0
) (
   input  logic               CLK,
   input  logic               rst,
   input  logic               stall,
   output logic [31:0]        imem_addr,
   input  logic [31:0]        imem_rdata,
   output logic [31:0]        dmem_addr,
   output logic [31:0]        dmem_wdata,
   output logic [3:0]         dmem_we,
   output logic               dmem_re,
   input  logic [31:0]        dmem_rdata,
   output logic [31:0]        ex_instr,
   output logic               fwd_valid,
   output logic [4:0]         fwd_reg,
   output logic               branch_taken,
   output logic               ctr_hit,
   input  mips_pkg::alu_op_t  alu_op,
   input  mips_pkg::src_a_t   src_a,
   input  mips_pkg::src_b_t   src_b,
   input  logic [1:0]         dst_sel,
   input  logic               reg_write,
   input  logic               mem_read,
   input  logic               mem_write,
   input  logic [1:0]         mem_size,
   input  logic               mem_signed,
   input  mips_pkg::wb_sel_t  wb_sel,
   input  mips_pkg::next_pc_t next_pc
);

   logic [31:0] pc, pc_next;
   logic [31:0] fe_pc4;
   logic        fe_valid;
   logic        stall_q;
   logic [31:0] instr_q, instr_now;
   logic [31:0] ld_q, ld_now;

   logic [4:0]  dst;
   logic [31:0] simm, zimm;
   logic [31:0] rd1, rd2, op_a, op_b, alu_result;
   logic [31:0] store_lanes, lane_data;
   logic [3:0]  byte_en;
   logic        cnt_clr;
   logic [31:0] cycle_cnt, instr_cnt;

   logic        wb_reg_write;
   mips_pkg::wb_sel_t wb_src;
   logic [31:0] wb_result, wb_link, wb_value;
   logic [4:0]  wb_dst;
   logic [1:0]  wb_size, wb_offset;
   logic        wb_signed, wb_cnt_sel;

   // fetch
   assign imem_addr = pc;

   always_comb begin
      case (next_pc)
         mips_pkg::NPC_BRANCH: pc_next = fe_pc4 + {simm[29:0], 2'b00};  // from delay slot
         mips_pkg::NPC_JUMP:   pc_next = {fe_pc4[31:28], ex_instr[25:0], 2'b00};
         mips_pkg::NPC_REG:    pc_next = op_a;
         default:              pc_next = pc + 32'd4;
      endcase
   end

   always_ff @(posedge CLK) begin
      if (rst) begin
         pc       <= RESET_PC;
         fe_valid <= 1'b0;
         stall_q  <= 1'b0;
      end else begin
         stall_q <= stall;
         if (!stall) begin
            pc       <= pc_next;
            fe_valid <= 1'b1;  // bubble only until the first fetch returns
         end
      end
   end

   always_ff @(posedge CLK) begin
      if (!stall) begin
         fe_pc4 <= pc + 32'd4;
      end
      instr_q <= instr_now;  // keeps memory words alive across a stall
      ld_q    <= ld_now;
   end

   // memory output moves on during stall, the copy does not
   assign instr_now = stall_q ? instr_q : imem_rdata;
   assign ld_now    = stall_q ? ld_q : dmem_rdata;
   assign ex_instr  = fe_valid ? instr_now : 32'h0;

   // execute
   assign simm = {{16{ex_instr[15]}}, ex_instr[15:0]};
   assign zimm = {16'h0, ex_instr[15:0]};

   reg_file u_rf (
      .CLK (CLK),
      .we  (wb_reg_write && !stall),
      .ra1 (ex_instr[25:21]),
      .ra2 (ex_instr[20:16]),
      .wa  (wb_dst),
      .wd  (wb_value),
      .rd1 (rd1),
      .rd2 (rd2)
   );

   always_comb begin
      case (src_a)
         mips_pkg::SRC_A_FWD:   op_a = wb_result;
         mips_pkg::SRC_A_SHAMT: op_a = {27'h0, ex_instr[10:6]};
         default:               op_a = rd1;
      endcase
      case (src_b)
         mips_pkg::SRC_B_FWD:  op_b = wb_result;
         mips_pkg::SRC_B_SIMM: op_b = simm;
         mips_pkg::SRC_B_ZIMM: op_b = zimm;
         default:              op_b = rd2;
      endcase
   end

   alu u_alu (
      .a      (op_a),
      .b      (op_b),
      .op     (alu_op),
      .result (alu_result)
   );

   // bit 26 turns beq into bne
   assign branch_taken = (op_a == op_b) ^ ex_instr[26];

   always_comb begin
      case (dst_sel)
         mips_pkg::DST_RD: dst = ex_instr[15:11];
         mips_pkg::DST_RA: dst = 5'd31;
         default:          dst = ex_instr[20:16];
      endcase
   end

   // store lanes follow the execute-stage size, load lanes the write-back size
   load_store_align u_st_align (
      .size        (mem_size),
      .sign_ext    (mem_signed),
      .ex_offset   (alu_result[1:0]),
      .wb_offset   (wb_offset),
      .store_data  (rd2),
      .mem_rdata   (ld_now),
      .lane_data   (),
      .store_lanes (store_lanes),
      .byte_en     (byte_en)
   );

   load_store_align u_ld_align (
      .size        (wb_size),
      .sign_ext    (wb_signed),
      .ex_offset   (alu_result[1:0]),
      .wb_offset   (wb_offset),
      .store_data  (rd2),
      .mem_rdata   (ld_now),
      .lane_data   (lane_data),
      .store_lanes (),
      .byte_en     ()
   );

   assign ctr_hit    = alu_result[31];  // counter window, only bit 31 decoded
   assign dmem_addr  = alu_result;
   assign dmem_wdata = store_lanes;
   assign dmem_we    = (mem_write && !ctr_hit && !stall) ? byte_en : 4'b0000;
   assign dmem_re    = mem_read && !ctr_hit && !stall;

   // counters
   assign cnt_clr = mem_write && ctr_hit && !stall && alu_result[3:2] == 2'b10;

   always_ff @(posedge CLK) begin
      if (rst || cnt_clr) begin
         cycle_cnt <= 32'h0;
         instr_cnt <= 32'h0;
      end else begin
         cycle_cnt <= cycle_cnt + 32'd1;  // runs through stall
         if (!stall && fe_valid) begin
            instr_cnt <= instr_cnt + 32'd1;
         end
      end
   end

   // write-back
   always_ff @(posedge CLK) begin
      if (rst) begin
         wb_reg_write <= 1'b0;
         wb_src       <= mips_pkg::WB_ALU;
      end else if (!stall) begin
         wb_reg_write <= reg_write && fe_valid;
         wb_src       <= wb_sel;
      end
   end

   always_ff @(posedge CLK) begin
      if (!stall) begin
         wb_result  <= alu_result;
         wb_dst     <= dst;
         wb_size    <= mem_size;
         wb_signed  <= mem_signed;
         wb_offset  <= alu_result[1:0];
         wb_cnt_sel <= alu_result[2];  // +4 selects instructions
         wb_link    <= fe_pc4 + 32'd4;
      end
   end

   always_comb begin
      case (wb_src)
         mips_pkg::WB_LOAD: wb_value = lane_data;
         mips_pkg::WB_CNT:  wb_value = wb_cnt_sel ? instr_cnt : cycle_cnt;
         mips_pkg::WB_LINK: wb_value = wb_link;
         default:           wb_value = wb_result;
      endcase
   end

   // only plain ALU results go back to execute
   assign fwd_valid = wb_reg_write && wb_src == mips_pkg::WB_ALU;
   assign fwd_reg   = wb_dst;

endmodule

// File: hdl/mips_core.sv
`timescale 1ns/1ps

module mips_core #(
   parameter logic [31:0] RESET_PC = 32'h0
) (
   input  logic        CLK,
   input  logic        rst,
   input  logic        stall,
   output logic [31:0] imem_addr,
   input  logic [31:0] imem_rdata,
   output logic [31:0] dmem_addr,
   output logic [31:0] dmem_wdata,
   output logic [3:0]  dmem_we,
   output logic        dmem_re,
   input  logic [31:0] dmem_rdata
);

   logic [31:0]        ex_instr;
   logic               fwd_valid;
   logic [4:0]         fwd_reg;
   logic               branch_taken;
   logic               ctr_hit;
   mips_pkg::alu_op_t  alu_op;
   mips_pkg::src_a_t   src_a;
   mips_pkg::src_b_t   src_b;
   logic [1:0]         dst_sel;
   logic               reg_write;
   logic               mem_read;
   logic               mem_write;
   logic [1:0]         mem_size;
   logic               mem_signed;
   mips_pkg::wb_sel_t  wb_sel;
   mips_pkg::next_pc_t next_pc;

   control_unit u_ctrl (
      .ex_instr     (ex_instr),
      .branch_taken (branch_taken),
      .fwd_valid    (fwd_valid),
      .fwd_reg      (fwd_reg),
      .ctr_hit      (ctr_hit),
      .alu_op       (alu_op),
      .src_a        (src_a),
      .src_b        (src_b),
      .dst_sel      (dst_sel),
      .reg_write    (reg_write),
      .mem_read     (mem_read),
      .mem_write    (mem_write),
      .mem_size     (mem_size),
      .mem_signed   (mem_signed),
      .wb_sel       (wb_sel),
      .next_pc      (next_pc)
   );

   datapath #(
      .RESET_PC (RESET_PC)
   ) u_dp (
      .CLK          (CLK),
      .rst          (rst),
      .stall        (stall),
      .imem_addr    (imem_addr),
      .imem_rdata   (imem_rdata),
      .dmem_addr    (dmem_addr),
      .dmem_wdata   (dmem_wdata),
      .dmem_we      (dmem_we),
      .dmem_re      (dmem_re),
      .dmem_rdata   (dmem_rdata),
      .ex_instr     (ex_instr),
      .fwd_valid    (fwd_valid),
      .fwd_reg      (fwd_reg),
      .branch_taken (branch_taken),
      .ctr_hit      (ctr_hit),
      .alu_op       (alu_op),
      .src_a        (src_a),
      .src_b        (src_b),
      .dst_sel      (dst_sel),
      .reg_write    (reg_write),
      .mem_read     (mem_read),
      .mem_write    (mem_write),
      .mem_size     (mem_size),
      .mem_signed   (mem_signed),
      .wb_sel       (wb_sel),
      .next_pc      (next_pc)
   );

endmodule

// File: dv/tb_mem_model.sv
`timescale 1ns/1ps

module tb_mem_model (
   input  logic        CLK,
   input  logic        stall_en,
   output logic        stall,
   input  logic [31:0] imem_addr,
   output logic [31:0] imem_rdata,
   input  logic [31:0] dmem_addr,
   input  logic [31:0] dmem_wdata,
   input  logic [3:0]  dmem_we,
   input  logic        dmem_re,
   output logic [31:0] dmem_rdata
);

   logic [31:0] imem [0:255];   // 1 KB program ROM
   logic [31:0] dmem [0:1023];  // 4 KB data RAM
   logic [31:0] lcg_state;

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1103515245 + 32'd12345;
   endfunction

   initial begin
      lcg_state  = 32'd20;  // seed
      stall      = 1'b0;
      imem_rdata = 32'h0;
      dmem_rdata = 32'h0;
   end

   always @(posedge CLK) begin
      imem_rdata <= imem[imem_addr[9:2]];
      dmem_rdata <= dmem_re ? dmem[dmem_addr[11:2]] : 32'hxxxx_xxxx;  // valid only after a read
      if (dmem_we[3]) dmem[dmem_addr[11:2]][31:24] <= dmem_wdata[31:24];
      if (dmem_we[2]) dmem[dmem_addr[11:2]][23:16] <= dmem_wdata[23:16];
      if (dmem_we[1]) dmem[dmem_addr[11:2]][15:8]  <= dmem_wdata[15:8];
      if (dmem_we[0]) dmem[dmem_addr[11:2]][7:0]   <= dmem_wdata[7:0];
      lcg_state <= lcg_next(lcg_state);
      stall     <= stall_en && lcg_state[16];  // roughly half the cycles
   end

endmodule

// File: dv/mips_core_tb.sv
`timescale 1ns/1ps

module mips_core_tb;

   localparam logic [31:0] MARKER = 32'h0000_600D;

   logic        CLK;
   logic        rst;
   logic        stall_en;
   logic        stall;
   logic [31:0] imem_addr, imem_rdata;
   logic [31:0] dmem_addr, dmem_wdata, dmem_rdata;
   logic [3:0]  dmem_we;
   logic        dmem_re;

   int          errors;
   int          err_start;
   int          tests_run;
   int          tests_failed;
   int          pc_idx;

   mips_core #(.RESET_PC(32'h0)) uut (
      .CLK        (CLK),
      .rst        (rst),
      .stall      (stall),
      .imem_addr  (imem_addr),
      .imem_rdata (imem_rdata),
      .dmem_addr  (dmem_addr),
      .dmem_wdata (dmem_wdata),
      .dmem_we    (dmem_we),
      .dmem_re    (dmem_re),
      .dmem_rdata (dmem_rdata)
   );

   tb_mem_model mem (
      .CLK        (CLK),
      .stall_en   (stall_en),
      .stall      (stall),
      .imem_addr  (imem_addr),
      .imem_rdata (imem_rdata),
      .dmem_addr  (dmem_addr),
      .dmem_wdata (dmem_wdata),
      .dmem_we    (dmem_we),
      .dmem_re    (dmem_re),
      .dmem_rdata (dmem_rdata)
   );

   always #20 CLK = ~CLK;

   // the memory side sees no access while it stalls
   always @(posedge CLK) begin
      if (stall) begin
         assert (dmem_we == 4'b0000 && !dmem_re) else begin
            $display("ERR %0t: memory access issued during stall, we %b re %b", $time,
                     dmem_we, dmem_re);
            errors++;
         end
      end
   end

   function automatic logic [31:0] rtype(input int fn, input int rs, input int rt,
                                         input int rd, input int sh);
      return {mips_pkg::OP_RTYPE, 5'(rs), 5'(rt), 5'(rd), 5'(sh), 6'(fn)};
   endfunction

   function automatic logic [31:0] itype(input logic [5:0] op, input int rs, input int rt,
                                         input int imm);
      return {op, 5'(rs), 5'(rt), 16'(imm)};
   endfunction

   function automatic logic [31:0] jtype(input logic [5:0] op, input int idx);
      return {op, 26'(idx)};  // word index of the target
   endfunction

   function automatic logic [31:0] fill_word(input logic [31:0] addr);
      return addr ^ 32'h5A5A_A5A5;
   endfunction

   // big-endian lanes, offset 0 is the top byte
   function automatic logic [31:0] load_rule(input logic [31:0] w, input int off,
                                             input bit half, input bit sgn);
      logic [7:0]  b;
      logic [15:0] h;
      if (half) begin
         h = w[31 - 8 * off -: 16];
         return {{16{sgn & h[15]}}, h};
      end
      b = w[31 - 8 * off -: 8];
      return {{24{sgn & b[7]}}, b};
   endfunction

   function automatic logic [31:0] store_rule(input logic [31:0] w, input int off,
                                              input bit half, input logic [31:0] d);
      logic [31:0] r;
      r = w;
      if (half) r[31 - 8 * off -: 16] = d[15:0];
      else r[31 - 8 * off -: 8] = d[7:0];
      return r;
   endfunction

   function automatic logic [5:0] ld_op(input int i);
      if (i < 4) return mips_pkg::OP_LB;
      if (i < 8) return mips_pkg::OP_LBU;
      if (i < 10) return mips_pkg::OP_LH;
      return mips_pkg::OP_LHU;
   endfunction

   function automatic int ld_off(input int i);
      if (i < 8) return i % 4;
      return (i % 2) * 2;
   endfunction

   task automatic put(input logic [31:0] w);
      mem.imem[pc_idx] = w;
      pc_idx++;
   endtask

   // rst held while the memories are refilled
   task automatic begin_program();
      @(posedge CLK);
      rst      <= 1'b1;
      stall_en <= 1'b0;
      for (int i = 0; i < 256; i++) mem.imem[i] = 32'h0;
      for (int i = 0; i < 1024; i++) mem.dmem[i] = fill_word(i * 4);
      pc_idx    = 0;
      err_start = errors;
   endtask

   task automatic run_program(input bit use_stall, input string name);
      int cycles;
      put(itype(mips_pkg::OP_ORI, 0, 29, MARKER));
      put(itype(mips_pkg::OP_SW, 0, 29, 32'h0FFC));
      put(jtype(mips_pkg::OP_J, pc_idx));  // spin here
      put(32'h0);
      @(posedge CLK);
      @(posedge CLK);
      rst      <= 1'b0;
      stall_en <= use_stall;
      cycles = 0;
      while (mem.dmem[1023] !== MARKER && cycles < 4000) begin
         @(posedge CLK);
         cycles++;
      end
      if (mem.dmem[1023] !== MARKER) begin
         $display("program did not finish in test %s", name);
         $display("Test failures found");
         $finish;
      end else begin
         stall_en <= 1'b0;
      end
   endtask

   task automatic check_word(input logic [31:0] addr, input logic [31:0] exp,
                             input string what);
      logic [31:0] got;
      got = mem.dmem[addr[11:2]];
      assert (got === exp) else begin
         $display("ERR %0t: %s at %h got %h expected %h", $time, what, addr, got, exp);
         errors++;
      end
   endtask

   task automatic end_test(input int num, input string name);
      tests_run++;
      if (errors == err_start) begin
         $display("test %0d %s: ok", num, name);
      end else begin
         tests_failed++;
         $display("test %0d %s: %0d errors", num, name, errors - err_start);
      end
   endtask

   task automatic arith_program();
      put(itype(mips_pkg::OP_ADDIU, 0, 1, 100));
      put(itype(mips_pkg::OP_ADDIU, 1, 2, -7));  // needs forwarding
      put(rtype(mips_pkg::FN_SUBU, 1, 2, 3, 0));
      put(itype(mips_pkg::OP_LUI, 0, 4, 16'h8765));
      put(itype(mips_pkg::OP_ORI, 4, 4, 16'h4321));
      put(rtype(mips_pkg::FN_XOR, 4, 1, 5, 0));
      put(rtype(mips_pkg::FN_AND, 4, 2, 6, 0));
      put(rtype(mips_pkg::FN_SLT, 4, 1, 7, 0));
      put(rtype(mips_pkg::FN_SRA, 0, 4, 8, 4));
      put(rtype(mips_pkg::FN_SRL, 0, 4, 9, 8));
      put(rtype(mips_pkg::FN_SLL, 0, 2, 10, 3));
      put(itype(mips_pkg::OP_ANDI, 4, 11, 16'hFF00));
      put(rtype(mips_pkg::FN_ADDU, 3, 3, 12, 0));
      for (int r = 2; r <= 12; r++) begin
         put(itype(mips_pkg::OP_SW, 0, r, 32'h100 + 4 * (r - 2)));
      end
   endtask

   task automatic check_arith();
      logic [31:0] a, b, c;
      a = 32'd100;
      b = a - 32'd7;
      c = 32'h8765_4321;
      check_word(32'h100, b, "addiu");
      check_word(32'h104, a - b, "subu");
      check_word(32'h108, c, "lui and ori");
      check_word(32'h10C, c ^ a, "xor");
      check_word(32'h110, c & b, "and");
      check_word(32'h114, ($signed(c) < $signed(a)) ? 32'd1 : 32'd0, "slt");
      check_word(32'h118, {{4{c[31]}}, c[31:4]}, "sra");
      check_word(32'h11C, {8'h0, c[31:8]}, "srl");
      check_word(32'h120, {b[28:0], 3'b000}, "sll");
      check_word(32'h124, c & 32'h0000_FF00, "andi");
      check_word(32'h128, (a - b) + (a - b), "addu");
   endtask

   initial begin
      CLK          = 1'b0;
      rst          = 1'b1;
      stall_en     = 1'b0;
      errors       = 0;
      tests_run    = 0;
      tests_failed = 0;

      begin_program();
      arith_program();
      run_program(1'b0, "arith");
      check_arith();
      end_test(1, "arithmetic");

      begin_program();
      mem.dmem[32'h200 >> 2] = 32'h807F_F102;
      for (int i = 0; i < 12; i++) begin
         put(itype(ld_op(i), 0, i + 1, 32'h200 + ld_off(i)));
         if (i > 0) put(itype(mips_pkg::OP_SW, 0, i, 32'h300 + 4 * (i - 1)));
      end
      put(itype(mips_pkg::OP_SW, 0, 12, 32'h300 + 4 * 11));
      run_program(1'b0, "loads");
      for (int i = 0; i < 12; i++) begin
         check_word(32'h300 + 4 * i,
                    load_rule(32'h807F_F102, ld_off(i), i >= 8,
                              ld_op(i) == mips_pkg::OP_LB || ld_op(i) == mips_pkg::OP_LH),
                    "sub-word load");
      end
      end_test(2, "sub-word loads");

      begin_program();
      put(itype(mips_pkg::OP_LUI, 0, 1, 16'h1122));
      put(itype(mips_pkg::OP_ORI, 1, 1, 16'h3344));
      for (int i = 0; i < 4; i++) put(itype(mips_pkg::OP_SB, 0, 1, 32'h400 + 5 * i));
      put(itype(mips_pkg::OP_SH, 0, 1, 32'h410));
      put(itype(mips_pkg::OP_SH, 0, 1, 32'h416));
      run_program(1'b0, "stores");
      for (int i = 0; i < 4; i++) begin
         check_word(32'h400 + 4 * i, store_rule(fill_word(32'h400 + 4 * i), i, 1'b0,
                    32'h1122_3344), "sb");
      end
      check_word(32'h410, store_rule(fill_word(32'h410), 0, 1'b1, 32'h1122_3344), "sh");
      check_word(32'h414, store_rule(fill_word(32'h414), 2, 1'b1, 32'h1122_3344), "sh");
      end_test(3, "sub-word stores");

      begin_program();
      put(rtype(mips_pkg::FN_ADDU, 0, 0, 3, 0));
      put(rtype(mips_pkg::FN_ADDU, 0, 0, 6, 0));  // r6 counts delay slots
      put(itype(mips_pkg::OP_ORI, 0, 1, 5));
      put(itype(mips_pkg::OP_BEQ, 1, 1, 2));      // taken, lands on index 6
      put(itype(mips_pkg::OP_ORI, 0, 2, 16'h11));
      put(itype(mips_pkg::OP_ORI, 0, 3, 16'h22)); // skipped
      put(itype(mips_pkg::OP_BNE, 1, 1, 5));      // not taken
      put(itype(mips_pkg::OP_ORI, 0, 4, 16'h33));
      put(itype(mips_pkg::OP_ORI, 0, 5, 16'h44));
      put(jtype(mips_pkg::OP_J, 12));
      put(itype(mips_pkg::OP_ADDIU, 6, 6, 1));
      put(itype(mips_pkg::OP_SW, 0, 1, 32'h51C)); // skipped
      put(jtype(mips_pkg::OP_JAL, 16));
      put(itype(mips_pkg::OP_ADDIU, 6, 6, 1));
      put(jtype(mips_pkg::OP_J, 18));             // return point
      put(itype(mips_pkg::OP_ADDIU, 6, 6, 1));
      put(rtype(mips_pkg::FN_JR, 31, 0, 0, 0));
      put(itype(mips_pkg::OP_ADDIU, 6, 6, 1));
      put(itype(mips_pkg::OP_SW, 0, 2, 32'h500));
      put(itype(mips_pkg::OP_SW, 0, 3, 32'h504));
      put(itype(mips_pkg::OP_SW, 0, 4, 32'h508));
      put(itype(mips_pkg::OP_SW, 0, 5, 32'h50C));
      put(itype(mips_pkg::OP_SW, 0, 6, 32'h510));
      put(itype(mips_pkg::OP_SW, 0, 31, 32'h518));
      run_program(1'b0, "control");
      check_word(32'h500, 32'h11, "beq delay slot");
      check_word(32'h504, 32'h0, "beq skipped instruction");
      check_word(32'h508, 32'h33, "bne delay slot");
      check_word(32'h50C, 32'h44, "bne fall-through");
      check_word(32'h510, 32'd4, "delay slot count");
      check_word(32'h518, 32'd12 * 4 + 32'd8, "jal link");
      check_word(32'h51C, fill_word(32'h51C), "skipped store");
      end_test(4, "control flow");

      begin_program();
      arith_program();
      run_program(1'b1, "stall");
      check_arith();
      end_test(5, "stall");

      begin_program();
      put(itype(mips_pkg::OP_LUI, 0, 1, mips_pkg::CNT_BASE >> 16));
      put(itype(mips_pkg::OP_SW, 1, 0, 8));         // clears both counters
      for (int i = 0; i < 3; i++) put(32'h0);
      put(itype(mips_pkg::OP_LW, 1, 2, 4));         // fourth after the clear
      put(itype(mips_pkg::OP_LW, 1, 3, 0));
      put(itype(mips_pkg::OP_SW, 0, 2, 32'h600));
      put(itype(mips_pkg::OP_SW, 0, 3, 32'h604));
      run_program(1'b0, "counters");
      check_word(32'h600, 32'd4, "instruction counter");
      check_word(32'h008, fill_word(32'h008), "counter clear kept off memory");
      assert (mem.dmem[32'h604 >> 2] >= mem.dmem[32'h600 >> 2]) else begin
         $display("ERR %0t: cycle counter %0d below instruction count %0d", $time,
                  mem.dmem[32'h604 >> 2], mem.dmem[32'h600 >> 2]);
         errors++;
      end
      end_test(6, "counters");

      $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
      if (errors == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

endmodule

// File: files.f
hdl/mips_pkg.sv
hdl/alu.sv
hdl/reg_file.sv
hdl/load_store_align.sv
hdl/control_unit.sv
hdl/datapath.sv
hdl/mips_core.sv
dv/tb_mem_model.sv
dv/mips_core_tb.sv
